/* cmo_subsys.f */
verilog/cmo_pkg.sv
verilog/dir_if.sv
verilog/cache_dir.sv
verilog/wbuf.sv
verilog/cmo_handler.sv
verilog/cmo_subsys_top.sv
testbench/tb_cmo_subsys.sv

/* testbench/cmo_golden.txt */
# F addr way | L addr hit way | C op addr wdata | W addr data ready
# H mshr_empty rtab_empty | M addr data | E closes the test
F 00010010 1
F 00020010 2
F 00030010 4
L 00010010 1 1
L 00020010 1 2
L 00030010 1 4
C 1 00020010 00000000
L 00020010 0 0
L 00010010 1 1
L 00030010 1 4
E
F 00010020 1
F 00020020 2
F 00030020 4
F 00040020 8
C 2 00000020 00000005
L 00010020 0 0
L 00020020 1 2
L 00030020 0 0
L 00040020 1 8
E
C 3 00000000 00000000
L 00010010 0 0
L 00040020 0 0
E
W 00001000 11111111 1
W 00002004 22222222 1
W 00001008 33333333 1
W 00003000 44444444 1
C 0 00000000 00000000
M 00001000 33333333
M 00002004 22222222
M 00003000 44444444
E
F 00050030 1
L 00050030 1 1
H 0 1
C 1 00050030 00000000
L 00050030 1 1
L 00050030 1 1
H 1 1
L 00050030 0 0
E
W 00004000 aaaa0000 1
W 00005000 bbbb0000 1
W 00006000 cccc0000 1
W 00007000 dddd0000 1
W 00008000 eeee0000 0
W 00005004 bbbbbbbb 1
C 0 00000000 00000000
M 00004000 aaaa0000
M 00005000 bbbbbbbb
M 00006000 cccc0000
M 00007000 dddd0000
W 00008000 eeeeeeee 1
E

/* testbench/tb_cmo_subsys.sv */
// ##############################
// CMO subsystem testbench
// Replays the golden command stream
// and checks directory, CMO and
// write buffer responses
// ##############################
`timescale 1ns/1ns
`default_nettype none

module tb_cmo_subsys;
    import cmo_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic     clk_i;
    logic     rst_ni;
    logic     cmo_valid_i;
    logic     cmo_ready_o;
    cmo_op_t  cmo_op_i;
    addr_t    cmo_addr_i;
    data_t    cmo_wdata_i;
    logic     mshr_empty_i;
    logic     rtab_empty_i;
    logic     fill_valid_i;
    logic     fill_ready_o;
    addr_t    fill_addr_i;
    way_vec_t fill_way_i;
    logic     lookup_valid_i;
    addr_t    lookup_addr_i;
    logic     lookup_hit_o;
    way_vec_t lookup_way_o;
    logic     wr_valid_i;
    logic     wr_ready_o;
    addr_t    wr_addr_i;
    data_t    wr_data_i;
    logic     mem_valid_o;
    logic     mem_ready_i;
    addr_t    mem_addr_o;
    data_t    mem_data_o;

    logic [31:0] lfsr_q;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    cmo_subsys_top #(
        .WBUF_DEPTH (4)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cmo_valid_i    (cmo_valid_i),
        .cmo_ready_o    (cmo_ready_o),
        .cmo_op_i       (cmo_op_i),
        .cmo_addr_i     (cmo_addr_i),
        .cmo_wdata_i    (cmo_wdata_i),
        .mshr_empty_i   (mshr_empty_i),
        .rtab_empty_i   (rtab_empty_i),
        .fill_valid_i   (fill_valid_i),
        .fill_ready_o   (fill_ready_o),
        .fill_addr_i    (fill_addr_i),
        .fill_way_i     (fill_way_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_addr_i  (lookup_addr_i),
        .lookup_hit_o   (lookup_hit_o),
        .lookup_way_o   (lookup_way_o),
        .wr_valid_i     (wr_valid_i),
        .wr_ready_o     (wr_ready_o),
        .wr_addr_i      (wr_addr_i),
        .wr_data_i      (wr_data_i),
        .mem_valid_o    (mem_valid_o),
        .mem_ready_i    (mem_ready_i),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o)
    );

    always #2 clk_i = ~clk_i;

    // Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("ERROR: %s", msg);
            test_errs++;
        end
    endtask

    task automatic do_fill(input addr_t addr, input way_vec_t way);
        int   n;
        logic done;
        fill_addr_i  = addr;
        fill_way_i   = way;
        fill_valid_i = 1'b1;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            done = fill_ready_o;
            step();
            n++;
        end
        fill_valid_i = 1'b0;
        check_true(done, "fill handshake timed out");
    endtask

    task automatic do_lookup(input addr_t addr, input logic hit, input way_vec_t way);
        lookup_addr_i  = addr;
        lookup_valid_i = 1'b1;
        step();
        lookup_valid_i = 1'b0;
        // Result is registered, valid in the following cycle
        @(negedge clk_i);
        check_val("lookup_hit_o", lookup_hit_o, hit);
        check_val("lookup_way_o", lookup_way_o, way);
        if (!(mshr_empty_i && rtab_empty_i)) begin
            check_true(!cmo_ready_o, "CMO finished while mshr or rtab was busy");
        end
        step();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!cmo_ready_o && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        check_true(cmo_ready_o, "CMO handler did not return to idle");
        step();
    endtask

    task automatic do_cmo(input cmo_op_t op, input addr_t addr, input data_t wdata);
        int   n;
        logic done;
        cmo_op_i    = op;
        cmo_addr_i  = addr;
        cmo_wdata_i = wdata;
        cmo_valid_i = 1'b1;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            done = cmo_ready_o;
            step();
            n++;
        end
        cmo_valid_i = 1'b0;
        check_true(done, "CMO request was not accepted");
        // Fences finish through memory transfers, held requests through a release
        if (op != CMO_FENCE && mshr_empty_i && rtab_empty_i) begin
            wait_idle();
        end
    endtask

    task automatic do_write(input addr_t addr, input data_t data, input logic ready);
        int   n;
        logic done;
        wr_addr_i  = addr;
        wr_data_i  = data;
        wr_valid_i = 1'b1;
        if (!ready) begin
            @(negedge clk_i);
            check_val("wr_ready_o", wr_ready_o, 1'b0);
            step();
        end else begin
            n    = 0;
            done = 1'b0;
            while (!done && n < WAIT_LIMIT) begin
                @(negedge clk_i);
                done = wr_ready_o;
                step();
                n++;
            end
            check_true(done, "write handshake timed out");
        end
        wr_valid_i = 1'b0;
    endtask

    task automatic expect_mem(input addr_t addr, input data_t data);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            lfsr_q      = lfsr_next(lfsr_q);
            mem_ready_i = lfsr_q[0];
            @(negedge clk_i);
            if (mem_valid_o && mem_ready_i) begin
                done = 1'b1;
                check_val("mem_addr_o", mem_addr_o, addr);
                check_val("mem_data_o", mem_data_o, data);
                check_true(!cmo_ready_o, "fence completed before its last memory transfer");
            end
            step();
            n++;
        end
        mem_ready_i = 1'b0;
        check_true(done, "no memory transfer within the timeout");
    endtask

    task automatic set_hold(input logic mshr_empty, input logic rtab_empty);
        mshr_empty_i = mshr_empty;
        rtab_empty_i = rtab_empty;
        step();
        if (mshr_empty && rtab_empty) begin
            wait_idle();
        end
    endtask

    task automatic end_test();
        wait_idle();
        @(negedge clk_i);
        check_true(!mem_valid_o, "memory request still pending at end of test");
        step();
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0d: ok", tests_run);
        end else begin
            $display("Test %0d: %0d errors", tests_run, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;

        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        cmo_valid_i    = 1'b0;
        cmo_op_i       = CMO_FENCE;
        cmo_addr_i     = '0;
        cmo_wdata_i    = '0;
        mshr_empty_i   = 1'b1;
        rtab_empty_i   = 1'b1;
        fill_valid_i   = 1'b0;
        fill_addr_i    = '0;
        fill_way_i     = '0;
        lookup_valid_i = 1'b0;
        lookup_addr_i  = '0;
        wr_valid_i     = 1'b0;
        wr_addr_i      = '0;
        wr_data_i      = '0;
        mem_ready_i    = 1'b0;
        lfsr_q         = 32'h19b5;
        test_errs      = 0;
        total_errs     = 0;
        tests_run      = 0;
        tests_failed   = 0;

        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        step();

        fd = $fopen("testbench/cmo_golden.txt", "r");
        check_true(fd != 0, "cannot open the golden command file");
        if (fd != 0) begin
            n = $fgets(line, fd);
            while (n != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    void'($sscanf(line, "%c %h %h %h", cmd, f1, f2, f3));
                    case (cmd)
                        "F": do_fill(f1, f2[NUM_WAYS-1:0]);
                        "L": do_lookup(f1, f2[0], f3[NUM_WAYS-1:0]);
                        "C": do_cmo(f1[1:0], f2, f3);
                        "W": do_write(f1, f2, f3[0]);
                        "H": set_hold(f1[0], f2[0]);
                        "M": expect_mem(f1, f2);
                        "E": end_test();
                        default: check_true(1'b0, "unknown command in the golden file");
                    endcase
                end
                n = $fgets(line, fd);
            end
            $fclose(fd);
        end
        total_errs += test_errs;

        $display("Tests run %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0 && tests_run > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cache_dir.sv */
// ##############################
// Cache directory
// Tags and valid bits per set and way,
// with fill, lookup, check and
// invalidate access
// ##############################
`timescale 1ns/1ns
`default_nettype none

module cache_dir (
    input  wire                     clk_i,
    input  wire                     rst_ni,

    input  wire                     fill_valid_i,
    output logic                    fill_ready_o,
    input  wire cmo_pkg::addr_t     fill_addr_i,
    input  wire cmo_pkg::way_vec_t  fill_way_i,

    input  wire                     lookup_valid_i,
    input  wire cmo_pkg::addr_t     lookup_addr_i,
    output logic                    lookup_hit_o,
    output cmo_pkg::way_vec_t       lookup_way_o,

    dir_if.directory                dir
);
    import cmo_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    tag_t                tag_q   [NUM_SETS][NUM_WAYS];

    set_t     fill_set;
    tag_t     fill_tag;
    set_t     lookup_set;
    tag_t     lookup_tag;
    logic     fill_xfer;
    way_vec_t lookup_match;
    way_vec_t check_match;
    way_vec_t lookup_way_q;
    way_vec_t hit_way_q;

    assign fill_set   = fill_addr_i[OFFSET_W +: SET_W];
    assign fill_tag   = fill_addr_i[OFFSET_W + SET_W +: TAG_W];
    assign lookup_set = lookup_addr_i[OFFSET_W +: SET_W];
    assign lookup_tag = lookup_addr_i[OFFSET_W + SET_W +: TAG_W];

    // Invalidation wins over a fill
    assign fill_ready_o = !dir.inval;
    assign fill_xfer    = fill_valid_i && fill_ready_o;
    assign dir.busy     = fill_xfer;

    // Compare all ways of the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookup_match[w] = valid_q[lookup_set][w] && (tag_q[lookup_set][w] == lookup_tag);
            check_match[w]  = valid_q[dir.check_set][w]
                              && (tag_q[dir.check_set][w] == dir.check_tag);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (dir.inval) begin
            valid_q[dir.inval_set] <= valid_q[dir.inval_set] & ~dir.inval_way;
        end else if (fill_xfer) begin
            valid_q[fill_set] <= valid_q[fill_set] | fill_way_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_xfer) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way_i[w]) begin
                    tag_q[fill_set][w] <= fill_tag;
                end
            end
        end
    end

    // Results are held only for one cycle after a request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_way_q <= '0;
            hit_way_q    <= '0;
        end else begin
            lookup_way_q <= lookup_valid_i ? lookup_match : '0;
            hit_way_q    <= dir.check ? check_match : '0;
        end
    end

    assign lookup_way_o = lookup_way_q;
    assign lookup_hit_o = |lookup_way_q;
    assign dir.hit_way  = hit_way_q;

    // A fill writes exactly one way
    a_fill_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        fill_xfer |-> $onehot(fill_way_i)
    );

endmodule

`default_nettype wire

/* verilog/cmo_handler.sv */
// ##############################
// CMO handler
// Sequences fences and the three
// kinds of directory invalidation
// ##############################
`timescale 1ns/1ns
`default_nettype none

module cmo_handler (
    input  wire                   clk_i,
    input  wire                   rst_ni,

    input  wire                   req_valid_i,
    output logic                  req_ready_o,
    input  wire cmo_pkg::cmo_op_t req_op_i,
    input  wire cmo_pkg::addr_t   req_addr_i,
    input  wire cmo_pkg::data_t   req_wdata_i,

    input  wire                   mshr_empty_i,
    input  wire                   rtab_empty_i,

    input  wire                   wbuf_empty_i,
    output logic                  wbuf_flush_all_o,

    dir_if.handler                dir
);
    import cmo_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FENCE_WAIT,
        ST_INVAL_WAIT,
        ST_CHECK_LINE,
        ST_INVAL_SET
    } state_t;

    state_t   state_q;
    state_t   state_d;
    cmo_op_t  op_q;
    addr_t    addr_q;
    way_vec_t way_q;
    set_t     set_cnt_q;
    set_t     set_cnt_d;
    set_t     req_set;
    logic     accept;
    logic     inval_ok;

    assign req_set   = addr_q[OFFSET_W +: SET_W];
    assign req_ready_o = (state_q == ST_IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // No refill or replay may be in flight during an invalidation
    assign inval_ok = mshr_empty_i && rtab_empty_i;

    assign dir.check_set = req_set;
    assign dir.check_tag = addr_q[OFFSET_W + SET_W +: TAG_W];

    always_comb begin
        state_d          = state_q;
        set_cnt_d        = set_cnt_q;
        wbuf_flush_all_o = 1'b0;
        dir.check        = 1'b0;
        dir.inval        = 1'b0;
        dir.inval_set    = req_set;
        dir.inval_way    = '0;

        unique case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    set_cnt_d = '0;
                    if (req_op_i == CMO_FENCE) begin
                        wbuf_flush_all_o = rtab_empty_i;
                        if (!(wbuf_empty_i && rtab_empty_i)) begin
                            state_d = ST_FENCE_WAIT;
                        end
                    end else if (!inval_ok) begin
                        state_d = ST_INVAL_WAIT;
                    end else if (req_op_i == CMO_INVAL_NLINE) begin
                        state_d = ST_CHECK_LINE;
                    end else begin
                        state_d = ST_INVAL_SET;
                    end
                end
            end
            ST_FENCE_WAIT: begin
                wbuf_flush_all_o = rtab_empty_i;
                if (wbuf_empty_i && rtab_empty_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_INVAL_WAIT: begin
                if (inval_ok) begin
                    state_d = (op_q == CMO_INVAL_NLINE) ? ST_CHECK_LINE : ST_INVAL_SET;
                end
            end
            ST_CHECK_LINE: begin
                // Directory tags may change under a fill
                if (!dir.busy) begin
                    dir.check = 1'b1;
                    state_d   = ST_INVAL_SET;
                end
            end
            ST_INVAL_SET: begin
                state_d = ST_IDLE;
                case (op_q)
                    CMO_INVAL_NLINE: begin
                        dir.inval     = |dir.hit_way;
                        dir.inval_way = dir.hit_way;
                    end
                    CMO_INVAL_SET: begin
                        dir.inval     = 1'b1;
                        dir.inval_way = way_q;
                    end
                    CMO_INVAL_ALL: begin
                        dir.inval     = 1'b1;
                        dir.inval_way = '1;
                        dir.inval_set = set_cnt_q;
                        set_cnt_d     = set_cnt_q + 1'b1;
                        if (set_cnt_q != set_t'(NUM_SETS - 1)) begin
                            state_d = ST_INVAL_SET;
                        end
                    end
                    default: begin
                        state_d = ST_IDLE;
                    end
                endcase
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request fields, way mask from the low write-data bits
    always_ff @(posedge clk_i) begin
        set_cnt_q <= set_cnt_d;
        if (accept) begin
            op_q   <= req_op_i;
            addr_q <= req_addr_i;
            way_q  <= req_wdata_i[NUM_WAYS-1:0];
        end
    end

    a_inval_state : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        dir.inval |-> (state_q == ST_INVAL_SET)
    );

    // A check never races a fill in the directory
    a_check_not_busy : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        dir.check |-> !dir.busy
    );

endmodule

`default_nettype wire

/* verilog/cmo_pkg.sv */
// ##############################
// CMO subsystem package
// Cache geometry, vector types and
// the cache operation codes
// ##############################
`default_nettype none

package cmo_pkg;

    // Address and data words
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // 16-byte lines, 16 sets of 4 ways
    localparam int OFFSET_W = 4;
    localparam int NUM_SETS = 16;
    localparam int NUM_WAYS = 4;

    localparam int SET_W   = $clog2(NUM_SETS);
    localparam int NLINE_W = ADDR_W - OFFSET_W;
    localparam int TAG_W   = NLINE_W - SET_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [SET_W-1:0]    set_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [NLINE_W-1:0]  nline_t;
    typedef logic [NUM_WAYS-1:0] way_vec_t;

    // Operation codes of the CMO request channel
    typedef logic [1:0] cmo_op_t;

    localparam cmo_op_t CMO_FENCE       = 2'd0;
    localparam cmo_op_t CMO_INVAL_NLINE = 2'd1;
    localparam cmo_op_t CMO_INVAL_SET   = 2'd2;
    localparam cmo_op_t CMO_INVAL_ALL   = 2'd3;

endpackage

`default_nettype wire

/* verilog/cmo_subsys_top.sv */
// ##############################
// CMO subsystem top level
// Connects directory, write buffer
// and CMO handler
// ##############################
`timescale 1ns/1ns
`default_nettype none

module cmo_subsys_top #(
    parameter int WBUF_DEPTH = 4
) (
    input  wire                     clk_i,
    input  wire                     rst_ni,

    input  wire                     cmo_valid_i,
    output logic                    cmo_ready_o,
    input  wire cmo_pkg::cmo_op_t   cmo_op_i,
    input  wire cmo_pkg::addr_t     cmo_addr_i,
    input  wire cmo_pkg::data_t     cmo_wdata_i,

    input  wire                     mshr_empty_i,
    input  wire                     rtab_empty_i,

    input  wire                     fill_valid_i,
    output logic                    fill_ready_o,
    input  wire cmo_pkg::addr_t     fill_addr_i,
    input  wire cmo_pkg::way_vec_t  fill_way_i,

    input  wire                     lookup_valid_i,
    input  wire cmo_pkg::addr_t     lookup_addr_i,
    output logic                    lookup_hit_o,
    output cmo_pkg::way_vec_t       lookup_way_o,

    input  wire                     wr_valid_i,
    output logic                    wr_ready_o,
    input  wire cmo_pkg::addr_t     wr_addr_i,
    input  wire cmo_pkg::data_t     wr_data_i,

    output logic                    mem_valid_o,
    input  wire                     mem_ready_i,
    output cmo_pkg::addr_t          mem_addr_o,
    output cmo_pkg::data_t          mem_data_o
);

    logic flush_all;
    logic wbuf_empty;

    dir_if dir_bus ();

    cache_dir dir_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .fill_valid_i   (fill_valid_i),
        .fill_ready_o   (fill_ready_o),
        .fill_addr_i    (fill_addr_i),
        .fill_way_i     (fill_way_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_addr_i  (lookup_addr_i),
        .lookup_hit_o   (lookup_hit_o),
        .lookup_way_o   (lookup_way_o),
        .dir            (dir_bus.directory)
    );

    wbuf #(
        .WBUF_DEPTH (WBUF_DEPTH)
    ) wbuf_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .wr_valid_i  (wr_valid_i),
        .wr_ready_o  (wr_ready_o),
        .wr_addr_i   (wr_addr_i),
        .wr_data_i   (wr_data_i),
        .flush_all_i (flush_all),
        .empty_o     (wbuf_empty),
        .mem_valid_o (mem_valid_o),
        .mem_ready_i (mem_ready_i),
        .mem_addr_o  (mem_addr_o),
        .mem_data_o  (mem_data_o)
    );

    cmo_handler handler_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (cmo_valid_i),
        .req_ready_o      (cmo_ready_o),
        .req_op_i         (cmo_op_i),
        .req_addr_i       (cmo_addr_i),
        .req_wdata_i      (cmo_wdata_i),
        .mshr_empty_i     (mshr_empty_i),
        .rtab_empty_i     (rtab_empty_i),
        .wbuf_empty_i     (wbuf_empty),
        .wbuf_flush_all_o (flush_all),
        .dir              (dir_bus.handler)
    );

endmodule

`default_nettype wire

/* verilog/dir_if.sv */
// ##############################
// Directory access interface
// Check and invalidate signals from
// the CMO handler to the directory
// ##############################
`timescale 1ns/1ns
`default_nettype none

interface dir_if;
    import cmo_pkg::*;

    // Tag check, result one cycle later
    logic     check;
    set_t     check_set;
    tag_t     check_tag;
    way_vec_t hit_way;

    // Valid bit clearing
    logic     inval;
    set_t     inval_set;
    way_vec_t inval_way;

    // Fill in progress
    logic     busy;

    modport handler (
        output check, check_set, check_tag,
        output inval, inval_set, inval_way,
        input  hit_way, busy
    );

    modport directory (
        input  check, check_set, check_tag,
        input  inval, inval_set, inval_way,
        output hit_way, busy
    );

endinterface

`default_nettype wire

/* verilog/wbuf.sv */
// ##############################
// Merging write buffer
// Write-through entries, merged per
// line, drained in order on a flush
// ##############################
`timescale 1ns/1ns
`default_nettype none

module wbuf #(
    parameter int WBUF_DEPTH = 4
) (
    input  wire                  clk_i,
    input  wire                  rst_ni,

    input  wire                  wr_valid_i,
    output logic                 wr_ready_o,
    input  wire cmo_pkg::addr_t  wr_addr_i,
    input  wire cmo_pkg::data_t  wr_data_i,

    input  wire                  flush_all_i,
    output logic                 empty_o,

    output logic                 mem_valid_o,
    input  wire                  mem_ready_i,
    output cmo_pkg::addr_t       mem_addr_o,
    output cmo_pkg::data_t       mem_data_o
);
    import cmo_pkg::*;

    localparam int PTR_W = (WBUF_DEPTH > 1) ? $clog2(WBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(WBUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    addr_t                 addr_q [WBUF_DEPTH];
    data_t                 data_q [WBUF_DEPTH];
    logic [WBUF_DEPTH-1:0] valid_q;
    logic [WBUF_DEPTH-1:0] flushed_q;
    ptr_t                  head_q;
    ptr_t                  tail_q;
    cnt_t                  count_q;

    nline_t wr_nline;
    logic   merge_hit;
    ptr_t   merge_idx;
    logic   full;
    logic   wr_xfer;
    logic   do_merge;
    logic   do_alloc;
    logic   do_retire;

    function automatic ptr_t ptr_inc(ptr_t p);
        if (p == ptr_t'(WBUF_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_nline = wr_addr_i[OFFSET_W +: NLINE_W];

    // Open entries are those not yet marked, and none are open while a flush is raised
    always_comb begin
        merge_hit = 1'b0;
        merge_idx = '0;
        for (int i = 0; i < WBUF_DEPTH; i++) begin
            if (!merge_hit && valid_q[i] && !flushed_q[i] && !flush_all_i
                    && (addr_q[i][OFFSET_W +: NLINE_W] == wr_nline)) begin
                merge_hit = 1'b1;
                merge_idx = ptr_t'(i);
            end
        end
    end

    assign full       = (count_q == cnt_t'(WBUF_DEPTH));
    assign wr_ready_o = !full || merge_hit;
    assign wr_xfer    = wr_valid_i && wr_ready_o;
    assign do_merge   = wr_xfer && merge_hit;
    assign do_alloc   = wr_xfer && !merge_hit;
    assign empty_o    = (count_q == '0);

    // Marked entries are always the oldest ones
    assign mem_valid_o = valid_q[head_q] && (flushed_q[head_q] || flush_all_i);
    assign mem_addr_o  = addr_q[head_q];
    assign mem_data_o  = data_q[head_q];
    assign do_retire   = mem_valid_o && mem_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= '0;
            flushed_q <= '0;
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
        end else begin
            if (flush_all_i) begin
                flushed_q <= flushed_q | valid_q;
            end
            if (do_alloc) begin
                valid_q[tail_q]   <= 1'b1;
                flushed_q[tail_q] <= 1'b0;
                tail_q            <= ptr_inc(tail_q);
            end
            if (do_retire) begin
                valid_q[head_q]   <= 1'b0;
                flushed_q[head_q] <= 1'b0;
                head_q            <= ptr_inc(head_q);
            end
            if (do_alloc && !do_retire) begin
                count_q <= count_q + 1'b1;
            end else if (!do_alloc && do_retire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_alloc) begin
            addr_q[tail_q] <= wr_addr_i;
            data_q[tail_q] <= wr_data_i;
        end
        if (do_merge) begin
            data_q[merge_idx] <= wr_data_i;
        end
    end

    a_count_bound : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        count_q <= cnt_t'(WBUF_DEPTH)
    );

    // Memory request stays put until taken
    a_mem_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_valid_o && !mem_ready_i |=>
            mem_valid_o && $stable(mem_addr_o) && $stable(mem_data_o)
    );

endmodule

`default_nettype wire
